// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the raster timing testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module vic_timing_tb \
    -Mdir obj_dir -o vic_timing_sim \
    && ./obj_dir/vic_timing_sim | tee sim.log

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/vic_timing_props.sv
module vic_timing_props (
    input logic       clk_dot4x,
    input logic       rst,
    input logic [9:0] raster_x,
    input logic [9:0] raster_x_max,
    input logic       hsync,
    input logic       blank,
    input logic       frame_start
);

    // Raster x stays inside the latched line length
    raster_x_in_line: assert property (
        @(posedge clk_dot4x) disable iff (rst) raster_x <= raster_x_max
    ) else $error("raster_x %0d beyond line end %0d", raster_x, raster_x_max);

    // Sync windows sit inside the blank windows
    hsync_in_blank: assert property (
        @(posedge clk_dot4x) disable iff (rst) hsync |-> blank
    ) else $error("hsync high while blank is low");

    frame_start_single: assert property (
        @(posedge clk_dot4x) disable iff (rst) frame_start |=> !frame_start
    ) else $error("frame_start high for two ticks in a row");

endmodule

// Raster and sync outputs meet in the top level, next to the latched line limit
bind vic_timing_top vic_timing_props u_timing_props (
    .clk_dot4x    (clk_dot4x),
    .rst          (rst),
    .raster_x     (raster_x),
    .raster_x_max (raster_x_max),
    .hsync        (hsync),
    .blank        (blank),
    .frame_start  (frame_start)
);

// File: testbench/vic_timing_tb.sv
module vic_timing_tb
    import vic_timing_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // Four ticks per dot, one dot per raster_x step
    localparam int FRAME_TICKS_6569 = (int'(X_MAX_6569) + 1) * (int'(Y_MAX_6569) + 1) * 4;
    localparam int WATCHDOG_TICKS   = 2 * FRAME_TICKS_6569 + 1000;
    localparam logic [9:0] XPOS_R8_JUMP = 10'h184;

    logic        clk_dot4x;
    logic        rst;
    chip_t       chip;
    logic        clk_phi;
    logic [6:0]  cycle_num;
    logic [9:0]  xpos;
    logic [9:0]  raster_x;
    logic [9:0]  sprite_raster_x;
    logic [8:0]  raster_line;
    logic [8:0]  raster_line_d;
    logic [5:0]  blink_ctr;
    logic [10:0] hires_raster_x;
    logic        hsync;
    logic        vsync;
    logic        blank;
    logic        frame_start;

    int errors;
    int checks;
    int tick_count = 0;
    int test_deadline;

    // Limits of the chip under test
    logic [9:0] exp_x_max;
    logic [8:0] exp_y_max;
    logic [9:0] exp_xpos_start;
    logic [9:0] exp_sprite_start;

    vic_timing_top DUT (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .chip            (chip),
        .clk_phi         (clk_phi),
        .cycle_num       (cycle_num),
        .xpos            (xpos),
        .raster_x        (raster_x),
        .sprite_raster_x (sprite_raster_x),
        .raster_line     (raster_line),
        .raster_line_d   (raster_line_d),
        .blink_ctr       (blink_ctr),
        .hires_raster_x  (hires_raster_x),
        .hsync           (hsync),
        .vsync           (vsync),
        .blank           (blank),
        .frame_start     (frame_start)
    );

    always #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;

    // Each test gets two PAL frames before the run is stopped
    always @(posedge clk_dot4x) begin
        tick_count <= tick_count + 1;
        if (tick_count > test_deadline) begin
            $display("Timeout: a test ran longer than two 6569 frames");
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic load_chip_limits(input chip_t c);
        case (c)
            CHIP6567R8: begin
                exp_x_max      = X_MAX_6567R8;
                exp_y_max      = Y_MAX_6567R8;
                exp_xpos_start = XPOS_START_NTSC;
            end
            CHIP6567R56A: begin
                exp_x_max      = X_MAX_6567R56A;
                exp_y_max      = Y_MAX_6567R56A;
                exp_xpos_start = XPOS_START_NTSC;
            end
            default: begin
                exp_x_max      = X_MAX_6569;
                exp_y_max      = Y_MAX_6569;
                exp_xpos_start = XPOS_START_PAL;
            end
        endcase
        exp_sprite_start = (c == CHIP6567R8) ? SPRITE_X_START_6567R8 : SPRITE_X_START_OTHER;
    endtask

    task automatic apply_reset(input chip_t c);
        @(posedge clk_dot4x);
        #1;
        chip          = c;
        rst           = 1'b1;
        test_deadline = tick_count + WATCHDOG_TICKS;
        load_chip_limits(c);
        repeat (3) @(posedge clk_dot4x);
        #1;
        rst = 1'b0;
    endtask

    // Returns at the first negedge that shows a new raster_x
    task automatic wait_raster_step();
        logic [9:0] start_x;
        start_x = raster_x;
        @(negedge clk_dot4x);
        while (raster_x == start_x) begin
            @(negedge clk_dot4x);
        end
    endtask

    task automatic test_reset_values(input chip_t c);
        int tick;
        apply_reset(c);
        @(negedge clk_dot4x);
        check_value("raster_x after reset", int'(raster_x), 0);
        check_value("raster_line after reset", int'(raster_line), 0);
        check_value("cycle_num after reset", int'(cycle_num), 0);
        check_value("xpos after reset", int'(xpos), int'(exp_xpos_start));
        check_value("sprite_raster_x after reset", int'(sprite_raster_x), int'(exp_sprite_start));
        // First tick after reset is phase 0, phi is high in the second half of each cycle
        for (tick = 0; tick < 64; tick++) begin
            check_value("clk_phi", int'(clk_phi), int'((tick % 32) >= 16));
            @(negedge clk_dot4x);
        end
    endtask

    task automatic test_line_wrap(input chip_t c);
        logic [9:0] prev_x;
        int         steps;
        apply_reset(c);
        prev_x = raster_x;
        wait_raster_step();
        steps = 1;
        while (raster_x != 10'd0) begin
            check_value("raster_x step", int'(raster_x), int'(prev_x) + 1);
            check_value("cycle_num vs raster_x", int'(cycle_num), int'(raster_x >> 3));
            prev_x = raster_x;
            wait_raster_step();
            steps++;
        end
        check_value("last raster_x of line", int'(prev_x), int'(exp_x_max));
        check_value("dot steps per line", steps, int'(exp_x_max) + 1);
        check_value("raster_line after line wrap", int'(raster_line), 1);
        check_value("cycle_num after line wrap", int'(cycle_num), 0);
    endtask

    task automatic test_xpos_path(input chip_t c);
        logic [9:0] prev_x;
        logic [9:0] model;
        logic       is_r8;
        logic       done;
        apply_reset(c);
        is_r8  = (c == CHIP6567R8);
        prev_x = raster_x;
        model  = exp_xpos_start;
        done   = 1'b0;
        while (!done) begin
            wait_raster_step();
            // Jumps are decided by the position the step leaves
            if (raster_x == 10'd0) begin
                model = exp_xpos_start;
                done  = 1'b1;
            end else if (prev_x == 10'd0) begin
                model = exp_xpos_start + 10'd1;
            end else if (prev_x == {7'd12, 3'd3}) begin
                model = 10'd0;
            end else if (is_r8 && (prev_x == {7'd60, 3'd7} || prev_x == {7'd61, 3'd3} ||
                                   prev_x == {7'd61, 3'd7})) begin
                model = XPOS_R8_JUMP;
            end else begin
                model = model + 10'd1;
            end
            check_value("xpos", int'(xpos), int'(model));
            prev_x = raster_x;
        end
    endtask

    task automatic test_frame_wrap(input chip_t c);
        logic [8:0] prev_line;
        logic [8:0] last_line;
        logic [8:0] exp_line_d;
        logic       last_phi;
        int         pulses;
        logic       wrapped;
        apply_reset(c);
        prev_line  = raster_line;
        last_line  = raster_line;
        last_phi   = clk_phi;
        exp_line_d = 9'd0;
        pulses     = 0;
        wrapped    = 1'b0;
        while (!wrapped) begin
            @(negedge clk_dot4x);
            if (frame_start) pulses++;
            // Delayed line takes the line of the previous tick only while phi was low
            if (!last_phi) begin
                exp_line_d = last_line;
            end
            check_value("raster_line_d", int'(raster_line_d), int'(exp_line_d));
            last_line = raster_line;
            last_phi  = clk_phi;
            if (raster_line != prev_line) begin
                if (raster_line == 9'd0) begin
                    wrapped = 1'b1;
                    check_value("last raster_line of frame", int'(prev_line), int'(exp_y_max));
                end else begin
                    check_value("raster_line step", int'(raster_line), int'(prev_line) + 1);
                end
                prev_line = raster_line;
            end
        end
        // frame_start trails the wrap by one tick
        repeat (4) begin
            @(negedge clk_dot4x);
            if (frame_start) pulses++;
        end
        check_value("frame_start pulses per frame", pulses, 1);
        check_value("blink_ctr after one frame", int'(blink_ctr), 1);
    endtask

    task automatic test_sync_windows(input chip_t c);
        logic [6:0] cyc;
        logic [8:0] line_num;
        logic       exp_hsync;
        logic       exp_vsync;
        logic       exp_blank;
        apply_reset(c);
        while (raster_line < VBLANK_LAST_LINE + 9'd2) begin
            wait_raster_step();
            cyc      = cycle_num;
            line_num = raster_line;
            @(negedge clk_dot4x);
            exp_hsync = (cyc >= HSYNC_FIRST_CYCLE) && (cyc <= HSYNC_LAST_CYCLE);
            exp_vsync = (line_num >= VSYNC_FIRST_LINE) && (line_num <= VSYNC_LAST_LINE);
            // Visible cycles lie strictly between the end and the start of hblank
            exp_blank = !((cyc > HBLANK_LAST_CYCLE) && (cyc < HBLANK_FIRST_CYCLE)) ||
                        ((line_num >= VBLANK_FIRST_LINE) && (line_num <= VBLANK_LAST_LINE));
            check_value("hsync", int'(hsync), int'(exp_hsync));
            check_value("vsync", int'(vsync), int'(exp_vsync));
            check_value("blank", int'(blank), int'(exp_blank));
        end
    endtask

    task automatic test_hires_counter(input chip_t c);
        logic [10:0] prev_h;
        logic        have_prev;
        int          steps;
        apply_reset(c);
        prev_h    = 11'd0;
        have_prev = 1'b0;
        // One full line and a few dots into the next
        for (steps = 0; steps < int'(exp_x_max) + 9; steps++) begin
            wait_raster_step();
            if (raster_x == 10'd0) begin
                check_value("hires_raster_x at line wrap", int'(hires_raster_x), 0);
            end else if (have_prev) begin
                check_value("hires_raster_x step", int'(hires_raster_x), int'(prev_h) + 2);
            end
            prev_h    = hires_raster_x;
            have_prev = 1'b1;
        end
    endtask

    task automatic run_chip_tests(input chip_t c);
        $display("Running tests for %s", c.name());
        test_reset_values(c);
        test_line_wrap(c);
        test_xpos_path(c);
        test_frame_wrap(c);
        test_sync_windows(c);
        test_hires_counter(c);
    endtask

    initial begin
        clk_dot4x     = 1'b0;
        rst           = 1'b1;
        chip          = CHIP6569;
        errors        = 0;
        checks        = 0;
        test_deadline = WATCHDOG_TICKS;
        run_chip_tests(CHIP6567R8);
        run_chip_tests(CHIP6569);
        run_chip_tests(CHIP6567R56A);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/dot_clock_gen.sv
module dot_clock_gen (
    input  logic clk_dot4x,
    input  logic rst,
    output logic clk_phi,
    output logic dot_rising_0,
    output logic dot_rising_2
);

    // 32 ticks of the 4x dot clock make one bus cycle
    logic [4:0] phase;
    logic [4:0] phase_nxt;

    assign phase_nxt = phase + 5'd1;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase <= 5'd0;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Strobes and phi are registered from the next phase so that
    // they line up with the phase value they describe
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            clk_phi      <= 1'b0;
            // Phase 0 comes right after reset, so its strobe is already up
            dot_rising_0 <= 1'b1;
            dot_rising_2 <= 1'b0;
        end else begin
            // Low half of the bus cycle is the video phase
            clk_phi      <= phase_nxt[4];
            dot_rising_0 <= (phase_nxt[1:0] == 2'd0);
            dot_rising_2 <= (phase_nxt[1:0] == 2'd2);
        end
    end

endmodule

// File: verilog/line_geometry.sv
module line_geometry
    import vic_timing_pkg::*;
(
    input  logic       clk_dot4x,
    input  logic       rst,
    input  chip_t      chip,
    input  logic       dot_rising_0,
    output logic [9:0] raster_x_max,
    output logic [8:0] raster_y_max,
    output logic [6:0] cycle_num
);

    // Dot within the current bus cycle
    logic [2:0] dot_ctr;
    logic       line_end;

    // cycle_num and dot_ctr together mirror raster_x
    assign line_end = ({cycle_num, dot_ctr} == raster_x_max);

    // Chip type only changes under reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_max <= chip_x_max(chip);
            raster_y_max <= chip_y_max(chip);
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_ctr   <= 3'd0;
            cycle_num <= 7'd0;
        end else if (dot_rising_0) begin
            if (line_end) begin
                dot_ctr   <= 3'd0;
                cycle_num <= 7'd0;
            end else begin
                dot_ctr <= dot_ctr + 3'd1;
                if (dot_ctr == 3'd7) begin
                    cycle_num <= cycle_num + 7'd1;
                end
            end
        end
    end

endmodule

// File: verilog/raster.sv
module raster
    import vic_timing_pkg::*;
(
    input  logic        clk_phi,
    input  logic        clk_dot4x,
    input  logic        rst,
    input  logic        dot_rising_0,
    input  logic        dot_rising_2,
    input  chip_t       chip,
    input  logic [6:0]  cycle_num,
    input  logic [9:0]  raster_x_max,
    input  logic [8:0]  raster_y_max,
    output logic [9:0]  xpos,
    output logic [9:0]  raster_x,
    output logic [9:0]  sprite_raster_x,
    output logic [8:0]  raster_line,
    output logic [8:0]  raster_line_d,
    output logic [5:0]  blink_ctr,
    output logic [10:0] hires_raster_x
);

    // Value xpos holds through the extra NTSC cycles on the 6567R8
    localparam logic [9:0] XPOS_R8_HOLD = 10'h184;

    // Pixel number within the bus cycle
    logic [2:0] cycle_bit;
    logic       line_end;
    logic       frame_end;
    logic       r8_hold;
    logic [9:0] xpos_start;
    logic [9:0] xpos_step;

    assign cycle_bit  = raster_x[2:0];
    assign line_end   = (raster_x >= raster_x_max);
    assign frame_end  = (raster_line >= raster_y_max);
    assign xpos_start = chip_xpos_start(chip);

    // 6567R8 stalls xpos at the end of the line to stretch it to 65 cycles
    assign r8_hold = (chip == CHIP6567R8) &&
                     ((cycle_num == 7'd60 && cycle_bit == 3'd7) ||
                      (cycle_num == 7'd61 && (cycle_bit == 3'd3 || cycle_bit == 3'd7)));

    // Next xpos inside a line, including the per-chip jumps
    always_comb begin
        if (cycle_num == 7'd0 && cycle_bit == 3'd0) begin
            xpos_step = xpos_start + 10'd1;
        end else if (cycle_num == 7'd12 && cycle_bit == 3'd3) begin
            xpos_step = 10'd0;
        end else if (r8_hold) begin
            xpos_step = XPOS_R8_HOLD;
        end else begin
            xpos_step = xpos + 10'd1;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x        <= 10'd0;
            hires_raster_x  <= 11'd0;
            raster_line     <= 9'd0;
            blink_ctr       <= 6'd0;
            xpos            <= xpos_start;
            sprite_raster_x <= chip_sprite_x_start(chip);
        end else begin
            if (dot_rising_0) begin
                if (!line_end) begin
                    raster_x       <= raster_x + 10'd1;
                    hires_raster_x <= hires_raster_x + 11'd1;
                    xpos           <= xpos_step;
                end else begin
                    // Back to the left edge of the next line
                    raster_x       <= 10'd0;
                    hires_raster_x <= 11'd0;
                    xpos           <= xpos_start;

                    if (!frame_end) begin
                        raster_line <= raster_line + 9'd1;
                    end else begin
                        raster_line <= 9'd0;
                        // Drives the hires blink attribute
                        blink_ctr   <= blink_ctr + 6'd1;
                    end
                end

                // Sprite x is zero at the first sprite 0 fetch slot
                if (sprite_raster_x < raster_x_max) begin
                    sprite_raster_x <= sprite_raster_x + 10'd1;
                end else begin
                    sprite_raster_x <= 10'd0;
                end
            end else if (dot_rising_2) begin
                // Half-dot step for hires modes
                hires_raster_x <= hires_raster_x + 11'd1;
            end
        end
    end

    // Line number as seen from the video half of the bus cycle
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_line_d <= 9'd0;
        end else if (!clk_phi) begin
            raster_line_d <= raster_line;
        end
    end

endmodule

// File: verilog/sync_gen.sv
module sync_gen
    import vic_timing_pkg::*;
(
    input  logic       clk_dot4x,
    input  logic       rst,
    input  logic [6:0] cycle_num,
    input  logic [9:0] raster_x,
    input  logic [8:0] raster_line,
    output logic       hsync,
    output logic       vsync,
    output logic       blank,
    output logic       frame_start
);

    logic [9:0] raster_x_prev;
    logic       hsync_win;
    logic       hblank_win;
    logic       vsync_win;
    logic       vblank_win;
    logic       frame_origin;

    assign hsync_win = (cycle_num >= HSYNC_FIRST_CYCLE) &&
                       (cycle_num <= HSYNC_LAST_CYCLE);

    // Blank starts late in one line and ends early in the next
    assign hblank_win = (cycle_num >= HBLANK_FIRST_CYCLE) ||
                        (cycle_num <= HBLANK_LAST_CYCLE);

    assign vsync_win = (raster_line >= VSYNC_FIRST_LINE) &&
                       (raster_line <= VSYNC_LAST_LINE);

    assign vblank_win = (raster_line >= VBLANK_FIRST_LINE) &&
                        (raster_line <= VBLANK_LAST_LINE);

    // Only the step into position 0,0 counts, not the time spent there
    assign frame_origin = (raster_x == 10'd0) &&
                          (raster_line == 9'd0) &&
                          (raster_x_prev != 10'd0);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_prev <= 10'd0;
            hsync         <= 1'b0;
            vsync         <= 1'b0;
            blank         <= 1'b0;
            frame_start   <= 1'b0;
        end else begin
            raster_x_prev <= raster_x;
            hsync         <= hsync_win;
            vsync         <= vsync_win;
            blank         <= hblank_win | vblank_win;
            frame_start   <= frame_origin;
        end
    end

endmodule

// File: verilog/vic_timing_pkg.sv
package vic_timing_pkg;

    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,
        CHIP6569     = 2'd1,
        CHIP6567R56A = 2'd2,
        CHIPUNUSED   = 2'd3
    } chip_t;

    // Last raster_x of a line (64, 65 and 63 cycles of 8 dots)
    localparam logic [9:0] X_MAX_6567R56A = 10'd511;
    localparam logic [9:0] X_MAX_6567R8   = 10'd519;
    localparam logic [9:0] X_MAX_6569     = 10'd503;

    // Last raster line of a frame
    localparam logic [8:0] Y_MAX_6567R56A = 9'd261;
    localparam logic [8:0] Y_MAX_6567R8   = 9'd262;
    localparam logic [8:0] Y_MAX_6569     = 9'd311;

    localparam logic [9:0] XPOS_START_NTSC       = 10'h19c;
    localparam logic [9:0] XPOS_START_PAL        = 10'h194;
    localparam logic [9:0] SPRITE_X_START_6567R8 = 10'd80;
    localparam logic [9:0] SPRITE_X_START_OTHER  = 10'd72;

    // Horizontal windows in bus cycles, blank wraps through the line end
    localparam logic [6:0] HSYNC_FIRST_CYCLE  = 7'd58;
    localparam logic [6:0] HSYNC_LAST_CYCLE   = 7'd61;
    localparam logic [6:0] HBLANK_FIRST_CYCLE = 7'd56;
    localparam logic [6:0] HBLANK_LAST_CYCLE  = 7'd9;

    // Vertical windows in raster lines
    localparam logic [8:0] VSYNC_FIRST_LINE  = 9'd14;
    localparam logic [8:0] VSYNC_LAST_LINE   = 9'd16;
    localparam logic [8:0] VBLANK_FIRST_LINE = 9'd13;
    localparam logic [8:0] VBLANK_LAST_LINE  = 9'd40;

    // Unused chip code falls back to the PAL part
    function automatic logic [9:0] chip_x_max(input chip_t chip);
        case (chip)
            CHIP6567R8:   return X_MAX_6567R8;
            CHIP6567R56A: return X_MAX_6567R56A;
            default:      return X_MAX_6569;
        endcase
    endfunction

    function automatic logic [8:0] chip_y_max(input chip_t chip);
        case (chip)
            CHIP6567R8:   return Y_MAX_6567R8;
            CHIP6567R56A: return Y_MAX_6567R56A;
            default:      return Y_MAX_6569;
        endcase
    endfunction

    function automatic logic [9:0] chip_xpos_start(input chip_t chip);
        case (chip)
            CHIP6567R8, CHIP6567R56A: return XPOS_START_NTSC;
            default:                  return XPOS_START_PAL;
        endcase
    endfunction

    function automatic logic [9:0] chip_sprite_x_start(input chip_t chip);
        if (chip == CHIP6567R8) begin
            return SPRITE_X_START_6567R8;
        end
        return SPRITE_X_START_OTHER;
    endfunction

endpackage

// File: verilog/vic_timing_top.sv
module vic_timing_top
    import vic_timing_pkg::*;
(
    input  logic        clk_dot4x,
    input  logic        rst,
    input  chip_t       chip,
    output logic        clk_phi,
    output logic [6:0]  cycle_num,
    output logic [9:0]  xpos,
    output logic [9:0]  raster_x,
    output logic [9:0]  sprite_raster_x,
    output logic [8:0]  raster_line,
    output logic [8:0]  raster_line_d,
    output logic [5:0]  blink_ctr,
    output logic [10:0] hires_raster_x,
    output logic        hsync,
    output logic        vsync,
    output logic        blank,
    output logic        frame_start
);

    logic       dot_rising_0;
    logic       dot_rising_2;
    logic [9:0] raster_x_max;
    logic [8:0] raster_y_max;

    dot_clock_gen u_dot_clock_gen (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .clk_phi      (clk_phi),
        .dot_rising_0 (dot_rising_0),
        .dot_rising_2 (dot_rising_2)
    );

    line_geometry u_line_geometry (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .chip         (chip),
        .dot_rising_0 (dot_rising_0),
        .raster_x_max (raster_x_max),
        .raster_y_max (raster_y_max),
        .cycle_num    (cycle_num)
    );

    raster u_raster (
        .clk_phi         (clk_phi),
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .dot_rising_0    (dot_rising_0),
        .dot_rising_2    (dot_rising_2),
        .chip            (chip),
        .cycle_num       (cycle_num),
        .raster_x_max    (raster_x_max),
        .raster_y_max    (raster_y_max),
        .xpos            (xpos),
        .raster_x        (raster_x),
        .sprite_raster_x (sprite_raster_x),
        .raster_line     (raster_line),
        .raster_line_d   (raster_line_d),
        .blink_ctr       (blink_ctr),
        .hires_raster_x  (hires_raster_x)
    );

    sync_gen u_sync_gen (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .cycle_num   (cycle_num),
        .raster_x    (raster_x),
        .raster_line (raster_line),
        .hsync       (hsync),
        .vsync       (vsync),
        .blank       (blank),
        .frame_start (frame_start)
    );

endmodule

// File: vlog.f
verilog/vic_timing_pkg.sv
verilog/dot_clock_gen.sv
verilog/line_geometry.sv
verilog/raster.sv
verilog/sync_gen.sv
verilog/vic_timing_top.sv
testbench/vic_timing_props.sv
testbench/vic_timing_tb.sv
